// ==== wrc_cfg_pkg.sv ====
`default_nettype none

package wrc_cfg_pkg;

    // --------------------------------------------------
    // datapath geometry
    // --------------------------------------------------
    localparam int unsigned LANE_W     = 32;
    localparam int unsigned N_BANKS    = 4;
    localparam int unsigned WORD_W     = LANE_W * N_BANKS;
    localparam int unsigned N_TAPS     = 9;
    localparam int unsigned BANK_W     = LANE_W * N_TAPS;
    localparam int unsigned ADDR_W     = 8;

    localparam int unsigned BANK_IDX_W = $clog2(N_BANKS);
    localparam int unsigned TAP_W      = $clog2(N_TAPS);

    // command buffer
    localparam int unsigned FIFO_DEPTH = 4;
    localparam int unsigned FIFO_PTR_W = $clog2(FIFO_DEPTH);
    localparam int unsigned FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);

    // --------------------------------------------------
    // weight ram address map
    // --------------------------------------------------
    // pw ping half a starts at 0
    localparam logic [ADDR_W-1:0] PW_BASE_B = 8'd80;
    localparam logic [ADDR_W-1:0] DW_BASE   = 8'd160;

    // one write into the banked weight ram
    typedef struct packed {
        logic [N_BANKS-1:0]             bank_mask;
        logic [ADDR_W-1:0]              addr;
        logic [N_BANKS-1:0][BANK_W-1:0] data;
        logic                           slice_last;
    } wr_cmd_t;

endpackage

`default_nettype wire

// ==== wrc_layer_pkg.sv ====
`default_nettype none

package wrc_layer_pkg;

    // group counters hold channels over banks
    localparam int unsigned GRP_W    = 4;
    localparam int unsigned N_LAYERS = 6;
    localparam int unsigned LAYER_W  = $clog2(N_LAYERS);

    typedef enum logic {
        L_DW = 1'b0,
        L_PW = 1'b1
    } layer_kind_t;

    typedef struct packed {
        layer_kind_t      kind;
        logic [GRP_W-1:0] ci_groups;
        logic [GRP_W-1:0] co_groups;
    } layer_cfg_t;

    // --------------------------------------------------
    // network layer table
    // --------------------------------------------------
    // co_groups is don't-care on dw rows
    localparam layer_cfg_t LAYER_TABLE [N_LAYERS] = '{
        '{kind: L_DW, ci_groups: 4'd2, co_groups: 4'd0},
        '{kind: L_PW, ci_groups: 4'd2, co_groups: 4'd2},
        '{kind: L_DW, ci_groups: 4'd4, co_groups: 4'd0},
        '{kind: L_PW, ci_groups: 4'd4, co_groups: 4'd1},
        '{kind: L_DW, ci_groups: 4'd1, co_groups: 4'd0},
        '{kind: L_PW, ci_groups: 4'd1, co_groups: 4'd2}
    };

endpackage

`default_nettype wire

// ==== wr_cmd_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface wr_cmd_if
    import wrc_cfg_pkg::*;
();
    logic    valid;
    logic    ready;
    wr_cmd_t cmd;

    // cmd is held while valid waits for ready
    modport producer (
        output valid,
        output cmd,
        input  ready
    );

    modport consumer (
        input  valid,
        input  cmd,
        output ready
    );

endinterface

`default_nettype wire

// ==== weight_slicer.sv ====
`timescale 1ns/1ps
`default_nettype none

module weight_slicer
    import wrc_cfg_pkg::*;
    import wrc_layer_pkg::*;
(
    input  wire                clk_data,
    input  wire                rst_n,
    input  wire                w_in_vld_i,
    input  wire  [WORD_W-1:0]  w_in_i,
    output logic               w_in_rdy_o,
    wr_cmd_if.producer         cmd_o
);

    layer_cfg_t                     cur_cfg;
    logic [LAYER_W-1:0]             layer_idx;
    logic [TAP_W-1:0]               tap_cnt;
    logic [GRP_W-1:0]               grp_cnt;
    logic [BANK_IDX_W-1:0]          bank_cnt;
    logic [GRP_W-1:0]               co_cnt;
    logic                           pp_sel;
    logic [N_TAPS-2:0][WORD_W-1:0]  taps_q;
    logic [N_TAPS-1:0][WORD_W-1:0]  taps_all;
    logic                           word_acc;
    logic                           is_dw;
    logic                           tap_last;
    logic                           grp_last;
    logic                           bank_last;
    logic                           co_last;
    logic                           layer_end;
    logic                           cmd_gen;
    wr_cmd_t                        cmd_d;
    wr_cmd_t                        cmd_q;
    logic                           cmd_vld_q;

    assign cur_cfg   = LAYER_TABLE[layer_idx];
    assign is_dw     = (cur_cfg.kind == L_DW);
    assign word_acc  = w_in_vld_i && w_in_rdy_o;
    assign tap_last  = (tap_cnt == TAP_W'(N_TAPS - 1));
    assign grp_last  = (grp_cnt == cur_cfg.ci_groups - 1'b1);
    assign bank_last = (bank_cnt == BANK_IDX_W'(N_BANKS - 1));
    assign co_last   = (co_cnt == cur_cfg.co_groups - 1'b1);
    assign layer_end = is_dw ? (tap_last && grp_last) : (grp_last && bank_last && co_last);
    assign cmd_gen   = word_acc && (!is_dw || tap_last);

    // --------------------------------------------------
    // layer sequencing and word counters
    // --------------------------------------------------
    // pw order is ci group, then bank, then co group
    always_ff @(posedge clk_data or negedge rst_n) begin
        if (!rst_n) begin
            layer_idx <= '0;
            tap_cnt   <= '0;
            grp_cnt   <= '0;
            bank_cnt  <= '0;
            co_cnt    <= '0;
            pp_sel    <= 1'b0;
        end else if (word_acc) begin
            if (is_dw) begin
                tap_cnt <= tap_last ? '0 : tap_cnt + 1'b1;
                if (tap_last) begin
                    grp_cnt <= grp_last ? '0 : grp_cnt + 1'b1;
                end
            end else begin
                grp_cnt <= grp_last ? '0 : grp_cnt + 1'b1;
                if (grp_last) begin
                    bank_cnt <= bank_last ? '0 : bank_cnt + 1'b1;
                    if (bank_last) begin
                        pp_sel <= ~pp_sel;
                        co_cnt <= co_last ? '0 : co_cnt + 1'b1;
                    end
                end
            end
            if (layer_end) begin
                layer_idx <= (layer_idx == LAYER_W'(N_LAYERS - 1)) ? '0 : layer_idx + 1'b1;
            end
        end
    end

    // tap 0 ends up in the lowest slot after eight shifts
    always_ff @(posedge clk_data) begin
        if (word_acc && is_dw) begin
            taps_q <= {w_in_i, taps_q[N_TAPS-2:1]};
        end
    end

    assign taps_all = {w_in_i, taps_q};

    // --------------------------------------------------
    // command build
    // --------------------------------------------------
    always_comb begin
        cmd_d = '0;
        if (is_dw) begin
            cmd_d.bank_mask  = '1;
            cmd_d.addr       = DW_BASE + ADDR_W'(grp_cnt);
            cmd_d.slice_last = 1'b1;
            // bank b gets lane b of every tap
            for (int b = 0; b < N_BANKS; b++) begin
                for (int t = 0; t < N_TAPS; t++) begin
                    cmd_d.data[b][t*LANE_W +: LANE_W] = taps_all[t][b*LANE_W +: LANE_W];
                end
            end
        end else begin
            cmd_d.bank_mask[bank_cnt] = 1'b1;
            cmd_d.addr       = pp_sel ? PW_BASE_B + ADDR_W'(grp_cnt) : ADDR_W'(grp_cnt);
            cmd_d.data[bank_cnt] = BANK_W'(w_in_i);
            cmd_d.slice_last = grp_last && bank_last;
        end
    end

    always_ff @(posedge clk_data or negedge rst_n) begin
        if (!rst_n) begin
            cmd_vld_q <= 1'b0;
        end else if (cmd_gen) begin
            cmd_vld_q <= 1'b1;
        end else if (cmd_o.ready) begin
            cmd_vld_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_data) begin
        if (cmd_gen) begin
            cmd_q <= cmd_d;
        end
    end

    // stall input while a command waits downstream
    assign w_in_rdy_o  = !cmd_vld_q || cmd_o.ready;
    assign cmd_o.valid = cmd_vld_q;
    assign cmd_o.cmd   = cmd_q;

    a_cmd_hold: assert property (@(posedge clk_data) disable iff (!rst_n)
        cmd_o.valid && !cmd_o.ready |=> cmd_o.valid && $stable(cmd_o.cmd));

endmodule

`default_nettype wire

// ==== wr_cmd_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module wr_cmd_fifo
    import wrc_cfg_pkg::*;
(
    input  wire         clk_data,
    input  wire         rst_n,
    wr_cmd_if.consumer  push_i,
    wr_cmd_if.producer  pop_o
);

    wr_cmd_t                mem [FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0]  wr_ptr;
    logic [FIFO_PTR_W-1:0]  rd_ptr;
    logic [FIFO_CNT_W-1:0]  count;
    logic                   full;
    logic                   push_fire;
    logic                   pop_fire;

    assign full      = (count == FIFO_CNT_W'(FIFO_DEPTH));
    // full fifo still takes a word when one leaves
    assign push_i.ready = !full || pop_o.ready;
    assign pop_o.valid  = (count != '0);
    assign pop_o.cmd    = mem[rd_ptr];
    assign push_fire = push_i.valid && push_i.ready;
    assign pop_fire  = pop_o.valid && pop_o.ready;

    always_ff @(posedge clk_data) begin
        if (push_fire) begin
            mem[wr_ptr] <= push_i.cmd;
        end
    end

    // --------------------------------------------------
    // pointers and occupancy
    // --------------------------------------------------
    always_ff @(posedge clk_data or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_fire) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop_fire) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push_fire, pop_fire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    a_cnt_bound: assert property (@(posedge clk_data) disable iff (!rst_n)
        count <= FIFO_CNT_W'(FIFO_DEPTH));

    // pointers that have met without a full fifo mean empty
    a_no_pop_empty: assert property (@(posedge clk_data) disable iff (!rst_n)
        pop_fire |-> (rd_ptr != wr_ptr) || full);

endmodule

`default_nettype wire

// ==== ram_w_writer.sv ====
`timescale 1ns/1ps
`default_nettype none

module ram_w_writer
    import wrc_cfg_pkg::*;
(
    input  wire                         clk_data,
    input  wire                         rst_n,
    wr_cmd_if.consumer                  cmd_i,
    output logic [N_BANKS-1:0]          ram_w_wr_en_o,
    output logic [ADDR_W-1:0]           ram_w_wr_addr_o,
    output logic [N_BANKS*BANK_W-1:0]   ram_w_wr_data_o,
    input  wire                         ram_w_wr_ready_i,
    output logic                        w_slice_done_o
);

    logic held_q;
    logic last_q;
    logic wr_done;
    logic load;

    assign wr_done     = held_q && ram_w_wr_ready_i;
    // take a new command when the held one leaves this cycle
    assign cmd_i.ready = !held_q || ram_w_wr_ready_i;
    assign load        = cmd_i.valid && cmd_i.ready;

    always_ff @(posedge clk_data or negedge rst_n) begin
        if (!rst_n) begin
            held_q         <= 1'b0;
            ram_w_wr_en_o  <= '0;
            w_slice_done_o <= 1'b0;
        end else begin
            if (load) begin
                held_q        <= 1'b1;
                ram_w_wr_en_o <= cmd_i.cmd.bank_mask;
            end else if (wr_done) begin
                held_q        <= 1'b0;
                ram_w_wr_en_o <= '0;
            end
            w_slice_done_o <= wr_done && last_q;
        end
    end

    always_ff @(posedge clk_data) begin
        if (load) begin
            ram_w_wr_addr_o <= cmd_i.cmd.addr;
            ram_w_wr_data_o <= cmd_i.cmd.data;
            last_q          <= cmd_i.cmd.slice_last;
        end
    end

    // slicer never emits an empty bank mask
    a_en_held: assert property (@(posedge clk_data) disable iff (!rst_n)
        held_q |-> ram_w_wr_en_o != '0);

endmodule

`default_nettype wire

// ==== w_rd_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module w_rd_ctrl
    import wrc_cfg_pkg::*;
(
    input  wire                         clk_data,
    input  wire                         rst_n,

    // weight word stream
    input  wire                         w_in_vld_i,
    input  wire  [WORD_W-1:0]           w_in_i,
    output wire                         w_in_rdy_o,

    // banked weight ram write port
    output wire  [N_BANKS-1:0]          ram_w_wr_en_o,
    output wire  [ADDR_W-1:0]           ram_w_wr_addr_o,
    output wire  [N_BANKS*BANK_W-1:0]   ram_w_wr_data_o,
    input  wire                         ram_w_wr_ready_i,
    output wire                         w_slice_done_o
);

    wr_cmd_if slicer_to_fifo ();
    wr_cmd_if fifo_to_writer ();

    // --------------------------------------------------
    // slicer, command buffer, ram writer
    // --------------------------------------------------
    weight_slicer i_weight_slicer (
        .clk_data   (clk_data),
        .rst_n      (rst_n),
        .w_in_vld_i (w_in_vld_i),
        .w_in_i     (w_in_i),
        .w_in_rdy_o (w_in_rdy_o),
        .cmd_o      (slicer_to_fifo)
    );

    wr_cmd_fifo i_wr_cmd_fifo (
        .clk_data (clk_data),
        .rst_n    (rst_n),
        .push_i   (slicer_to_fifo),
        .pop_o    (fifo_to_writer)
    );

    ram_w_writer i_ram_w_writer (
        .clk_data         (clk_data),
        .rst_n            (rst_n),
        .cmd_i            (fifo_to_writer),
        .ram_w_wr_en_o    (ram_w_wr_en_o),
        .ram_w_wr_addr_o  (ram_w_wr_addr_o),
        .ram_w_wr_data_o  (ram_w_wr_data_o),
        .ram_w_wr_ready_i (ram_w_wr_ready_i),
        .w_slice_done_o   (w_slice_done_o)
    );

endmodule

`default_nettype wire

// ==== tb_w_rd_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_w_rd_ctrl
    import wrc_cfg_pkg::*;
    import wrc_layer_pkg::*;
();

    typedef logic [N_BANKS-1:0][BANK_W-1:0] bank_data_t;

    localparam int          CLK_PERIOD_NS   = 100;
    localparam int          RESET_CYCLES    = 16;
    localparam logic [31:0] SEED            = 32'h9378fdac;
    localparam int          WORDS_L0        = 18;
    localparam int          WORDS_L1        = 16;
    localparam int          WORDS_WRAP      = 87;
    localparam int          WORDS_BP        = 52;
    localparam int          TOTAL_WORDS     = WORDS_L0 + WORDS_L1 + WORDS_WRAP + WORDS_BP;
    localparam int          CYCLES_PER_WORD = 40;
    localparam int          WATCHDOG_NS     =
        (TOTAL_WORDS * CYCLES_PER_WORD + RESET_CYCLES) * CLK_PERIOD_NS;

    logic                       clk_data;
    logic                       rst_n;
    logic                       w_in_vld;
    logic [WORD_W-1:0]          w_in;
    logic                       w_in_rdy;
    logic [N_BANKS-1:0]         ram_en;
    logic [ADDR_W-1:0]          ram_addr;
    logic [N_BANKS*BANK_W-1:0]  ram_data;
    logic                       ram_ready = 1'b1;
    logic                       slice_done;

    logic [31:0]                w_state = SEED;
    logic [31:0]                stall_state = SEED;
    logic [1:0]                 ready_mode;
    logic                       saw_stall;

    // reference model state
    int                         m_layer;
    int                         m_pos;
    logic                       m_pp;
    logic [WORD_W-1:0]          m_taps [N_TAPS];
    int                         exp_slices;
    logic [N_BANKS-1:0]         exp_en [$];
    logic [ADDR_W-1:0]          exp_addr [$];
    bank_data_t                 exp_data [$];

    // writes seen on the ram port
    logic [N_BANKS-1:0]         got_en [$];
    logic [ADDR_W-1:0]          got_addr [$];
    bank_data_t                 got_data [$];
    int                         got_base;
    int                         slice_seen = 0;

    int                         n_tests;
    int                         n_failing;
    int                         n_errors;

    w_rd_ctrl i_w_rd_ctrl (
        .clk_data         (clk_data),
        .rst_n            (rst_n),
        .w_in_vld_i       (w_in_vld),
        .w_in_i           (w_in),
        .w_in_rdy_o       (w_in_rdy),
        .ram_w_wr_en_o    (ram_en),
        .ram_w_wr_addr_o  (ram_addr),
        .ram_w_wr_data_o  (ram_data),
        .ram_w_wr_ready_i (ram_ready),
        .w_slice_done_o   (slice_done)
    );

    initial begin
        clk_data = 1'b0;
        forever #(CLK_PERIOD_NS / 2) clk_data = ~clk_data;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before the tests completed");
        $display("tests failed");
        $finish;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // 0 always ready, 1 random stalls, 2 held low
    always @(posedge clk_data) begin
        stall_state <= lcg_next(stall_state);
        case (ready_mode)
            2'd1:    ram_ready <= (stall_state[31:30] != 2'b00);
            2'd2:    ram_ready <= 1'b0;
            default: ram_ready <= 1'b1;
        endcase
    end

    // a write completes on the next rising edge
    always @(negedge clk_data) begin
        if (rst_n) begin
            if (ram_en != '0 && ram_ready) begin
                got_en.push_back(ram_en);
                got_addr.push_back(ram_addr);
                got_data.push_back(bank_data_t'(ram_data));
            end
            if (slice_done) begin
                slice_seen++;
            end
        end
    end

    // --------------------------------------------------
    // compare tasks
    // --------------------------------------------------
    task automatic check_en(input string name, input logic [N_BANKS-1:0] got,
                            input logic [N_BANKS-1:0] exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            n_errors++;
        end
    endtask

    task automatic check_addr(input string name, input logic [ADDR_W-1:0] got,
                              input logic [ADDR_W-1:0] exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
            n_errors++;
        end
    endtask

    task automatic check_data(input string name, input bank_data_t got, input bank_data_t exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            n_errors++;
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
            n_errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
            n_errors++;
        end
    endtask

    // --------------------------------------------------
    // reference model stepped one word at a time
    // --------------------------------------------------
    task automatic model_word(input logic [WORD_W-1:0] w);
        layer_cfg_t         cfg;
        int                 ci_n;
        int                 len;
        int                 tap;
        int                 ci;
        int                 bank;
        logic [N_BANKS-1:0] en;
        bank_data_t         d;
        cfg  = LAYER_TABLE[m_layer];
        ci_n = int'(cfg.ci_groups);
        d    = '0;
        if (cfg.kind == L_DW) begin
            len = ci_n * N_TAPS;
            tap = m_pos % N_TAPS;
            m_taps[tap] = w;
            if (tap == N_TAPS - 1) begin
                for (int b = 0; b < N_BANKS; b++) begin
                    for (int t = 0; t < N_TAPS; t++) begin
                        d[b][t*LANE_W +: LANE_W] = m_taps[t][b*LANE_W +: LANE_W];
                    end
                end
                exp_en.push_back('1);
                exp_addr.push_back(DW_BASE + ADDR_W'(m_pos / N_TAPS));
                exp_data.push_back(d);
                exp_slices++;
            end
        end else begin
            len  = ci_n * N_BANKS * int'(cfg.co_groups);
            ci   = m_pos % ci_n;
            bank = (m_pos / ci_n) % N_BANKS;
            en   = '0;
            en[bank] = 1'b1;
            d[bank]  = {{(BANK_W - WORD_W){1'b0}}, w};
            exp_en.push_back(en);
            exp_addr.push_back(m_pp ? PW_BASE_B + ADDR_W'(ci) : ADDR_W'(ci));
            exp_data.push_back(d);
            if (ci == ci_n - 1 && bank == N_BANKS - 1) begin
                exp_slices++;
                m_pp = ~m_pp;
            end
        end
        m_pos++;
        if (m_pos == len) begin
            m_pos   = 0;
            m_layer = (m_layer + 1) % N_LAYERS;
        end
    endtask

    task automatic next_word(output logic [WORD_W-1:0] w);
        for (int l = 0; l < N_BANKS; l++) begin
            w_state = lcg_next(w_state);
            w[l*LANE_W +: LANE_W] = w_state;
        end
    endtask

    // --------------------------------------------------
    // stimulus and collection
    // --------------------------------------------------
    task automatic feed_words(input int n);
        logic [WORD_W-1:0] w;
        for (int i = 0; i < n; i++) begin
            next_word(w);
            model_word(w);
            @(posedge clk_data);
            w_in_vld <= 1'b1;
            w_in     <= w;
            @(negedge clk_data);
            while (!w_in_rdy) begin
                saw_stall = 1'b1;
                @(negedge clk_data);
            end
        end
        @(posedge clk_data);
        w_in_vld <= 1'b0;
    endtask

    task automatic wait_writes(input string test);
        int budget;
        budget = 100 + exp_en.size() * CYCLES_PER_WORD;
        while (got_en.size() - got_base < exp_en.size() && budget > 0) begin
            @(negedge clk_data);
            budget--;
        end
        if (got_en.size() - got_base < exp_en.size()) begin
            $display("%s: timed out waiting for RAM writes", test);
            n_errors++;
        end
        repeat (4) @(negedge clk_data);
    endtask

    task automatic compare_writes(input string test);
        int n_got;
        n_got = got_en.size() - got_base;
        if (n_got != exp_en.size()) begin
            $display("%s: expected %0d RAM writes but saw %0d", test, exp_en.size(), n_got);
            n_errors++;
        end else begin
            for (int i = 0; i < exp_en.size(); i++) begin
                check_en($sformatf("ram_w_wr_en_o (write %0d)", i),
                         got_en[got_base + i], exp_en[i]);
                check_addr($sformatf("ram_w_wr_addr_o (write %0d)", i),
                           got_addr[got_base + i], exp_addr[i]);
                check_data($sformatf("ram_w_wr_data_o (write %0d)", i),
                           got_data[got_base + i], exp_data[i]);
            end
        end
        got_base = got_en.size();
        exp_en.delete();
        exp_addr.delete();
        exp_data.delete();
    endtask

    task automatic finish_test(input string test, input int err_before);
        n_tests++;
        if (n_errors == err_before) begin
            $display("[%0t] %s: ok", $time, test);
        end else begin
            $display("[%0t] %s: %0d errors", $time, test, n_errors - err_before);
            n_failing++;
        end
    endtask

    task automatic run_words(input string test, input int n);
        int err_before;
        err_before = n_errors;
        feed_words(n);
        wait_writes(test);
        compare_writes(test);
        finish_test(test, err_before);
    endtask

    // --------------------------------------------------
    // directed tests
    // --------------------------------------------------
    task automatic test_reset();
        int err_before;
        err_before = n_errors;
        check_en("ram_w_wr_en_o", ram_en, '0);
        check_flag("w_slice_done_o", slice_done, 1'b0);
        check_flag("w_in_rdy_o", w_in_rdy, 1'b1);
        finish_test("after reset", err_before);
    endtask

    task automatic test_layers_wrap();
        int err_before;
        err_before = n_errors;
        feed_words(WORDS_WRAP);
        wait_writes("layers 2-5 and wrap");
        compare_writes("layers 2-5 and wrap");
        // the last two writes belong to layer 0 again
        if (got_base >= 2) begin
            check_addr("ram_w_wr_addr_o (wrap)", got_addr[got_base - 2], DW_BASE);
            check_addr("ram_w_wr_addr_o (wrap)", got_addr[got_base - 1], DW_BASE + 8'd1);
        end
        finish_test("layers 2-5 and wrap", err_before);
    endtask

    task automatic test_back_pressure();
        int err_before;
        err_before = n_errors;
        saw_stall  = 1'b0;
        @(negedge clk_data);
        ready_mode = 2'd2;
        fork
            feed_words(WORDS_BP);
            begin
                repeat (30) @(negedge clk_data);
                ready_mode = 2'd1;
            end
        join
        wait_writes("back-pressure");
        compare_writes("back-pressure");
        check_flag("w_in_rdy_o low during stall", saw_stall, 1'b1);
        @(negedge clk_data);
        ready_mode = 2'd0;
        finish_test("back-pressure", err_before);
    endtask

    task automatic test_slice_count();
        int err_before;
        err_before = n_errors;
        repeat (4) @(negedge clk_data);
        check_count("w_slice_done_o pulses", slice_seen, exp_slices);
        finish_test("slice count", err_before);
    endtask

    initial begin
        rst_n      <= 1'b0;
        w_in_vld   <= 1'b0;
        w_in       <= '0;
        ready_mode = 2'd0;
        saw_stall  = 1'b0;
        m_layer    = 0;
        m_pos      = 0;
        m_pp       = 1'b0;
        exp_slices = 0;
        got_base   = 0;
        n_tests    = 0;
        n_failing  = 0;
        n_errors   = 0;

        repeat (RESET_CYCLES) @(posedge clk_data);
        rst_n <= 1'b1;
        @(negedge clk_data);

        test_reset();
        run_words("layer 0 dw", WORDS_L0);
        run_words("layer 1 pw", WORDS_L1);
        test_layers_wrap();
        test_back_pressure();
        test_slice_count();

        $display("summary: %0d tests run, %0d with errors, %0d failed checks",
                 n_tests, n_failing, n_errors);
        if (n_errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== w_rd_ctrl.f ====
wrc_cfg_pkg.sv
wrc_layer_pkg.sv
wr_cmd_if.sv
weight_slicer.sv
wr_cmd_fifo.sv
ram_w_writer.sv
w_rd_ctrl.sv
tb_w_rd_ctrl.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -sv \
    --top-module tb_w_rd_ctrl \
    -f w_rd_ctrl.f \
    -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
    echo "verilator build did not succeed"
    exit 1
fi

out="$(./obj_dir/sim_tb 2>&1)"
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "all tests passed"; then
    exit 0
fi
exit 1
